// ==== vlog.f ====
+incdir+include
source/bpu_pkg.sv
source/branch_update_if.sv
source/bht.sv
source/btb.sv
source/bpu.sv
source/fetch_predict_top.sv
tb/tb_fetch_predict.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fetch predictor testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_fetch_predict \
    -f vlog.f \
    && ./obj_dir/Vtb_fetch_predict | tee /dev/stderr | grep -q "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tb/tb_fetch_predict.sv ====
`include "bpu_cfg.svh"

module tb_fetch_predict
    import bpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic   is_branch_1;
        logic   is_branch_2;
        logic   pre_taken;
        addr_t  pre_branch_addr;
        logic   fetch_inst_1_en;
        logic   fetch_inst_2_en;
        logic   is_exception;
        ecode_t exception_cause;
    } expect_t;

    localparam addr_t BR_A   = 32'h0000_1040;
    localparam addr_t TGT_A  = 32'h0000_8000;
    localparam addr_t BR_B   = 32'h0000_1044;
    localparam addr_t TGT_B  = 32'h0000_9100;
    // bit 12 lies in the btb tag but above the bht index
    localparam addr_t ALIAS  = BR_B ^ 32'h0000_1000;
    localparam inst_t BR_WORD  = 32'h5800_0010;
    localparam inst_t ALU_WORD = 32'h0028_0000;

    logic   clk = 1'b0;
    logic   arst_n;
    addr_t  pc;
    inst_t  inst_1;
    inst_t  inst_2;
    logic   inst_en_1;
    logic   inst_en_2;
    logic   pause;
    logic   stall;
    logic   fetch_exception;
    ecode_t fetch_ecode;
    logic   update_en;
    addr_t  update_pc;
    logic   update_taken;
    addr_t  update_target;
    logic   branch_flush;
    logic   is_branch_1;
    logic   is_branch_2;
    logic   pre_taken;
    addr_t  pre_branch_addr;
    logic   fetch_inst_1_en;
    logic   fetch_inst_2_en;
    logic   is_exception;
    ecode_t exception_cause;

    int     seed;
    string  test_name = "reset";
    logic   checks_on = 1'b0;

    fetch_predict_top dut_i (.*);

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    counter_t   model_cnt    [`BHT_ENTRIES];
    logic       model_valid  [`BTB_ENTRIES];
    btb_tag_t   model_tag    [`BTB_ENTRIES];
    addr_t      model_target [`BTB_ENTRIES];
    logic       model_exc;
    ecode_t     model_ecode;
    bht_index_t upd_hi;
    btb_index_t upd_ti;

    assign upd_hi = update_pc[`PC_INDEX_LSB +: `BHT_INDEX_BITS];
    assign upd_ti = update_pc[`PC_INDEX_LSB +: `BTB_INDEX_BITS];

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                model_cnt[i] <= 2'd1;
            end
            for (int j = 0; j < `BTB_ENTRIES; j++) begin
                model_valid[j] <= 1'b0;
            end
            model_exc   <= 1'b0;
            model_ecode <= '0;
        end else begin
            model_exc   <= fetch_exception;
            model_ecode <= fetch_ecode;
            if (update_en && update_taken) begin
                if (model_cnt[upd_hi] != 2'd3) begin
                    model_cnt[upd_hi] <= model_cnt[upd_hi] + 2'd1;
                end
                model_valid[upd_ti]  <= 1'b1;
                model_tag[upd_ti]    <= update_pc[`BTB_TAG_LSB +: `BTB_TAG_BITS];
                model_target[upd_ti] <= update_target;
            end else if (update_en && (model_cnt[upd_hi] != 2'd0)) begin
                model_cnt[upd_hi] <= model_cnt[upd_hi] - 2'd1;
            end
        end
    end

    function automatic logic in_branch_range(opcode_t op);
        return (op >= BR_OPCODE_FIRST) && (op <= BR_OPCODE_LAST);
    endfunction

    function automatic logic slot_taken(addr_t a, inst_t w, logic en);
        bht_index_t hi;
        btb_index_t ti;
        hi = a[`PC_INDEX_LSB +: `BHT_INDEX_BITS];
        ti = a[`PC_INDEX_LSB +: `BTB_INDEX_BITS];
        return en && in_branch_range(w[31:26]) && (model_cnt[hi] >= 2'd2)
            && model_valid[ti] && (model_tag[ti] == a[`BTB_TAG_LSB +: `BTB_TAG_BITS]);
    endfunction

    function automatic expect_t predict_outputs();
        expect_t e;
        addr_t   pc_2;
        logic    take_1;
        logic    take_2;
        pc_2              = pc + 32'd4;
        take_1            = slot_taken(pc, inst_1, inst_en_1);
        take_2            = slot_taken(pc_2, inst_2, inst_en_2);
        e.is_branch_1     = in_branch_range(inst_1[31:26]);
        e.is_branch_2     = in_branch_range(inst_2[31:26]);
        e.is_exception    = model_exc;
        e.exception_cause = model_ecode;
        e.fetch_inst_1_en = inst_en_1;
        e.fetch_inst_2_en = inst_en_2;
        e.pre_taken       = 1'b0;
        e.pre_branch_addr = '0;
        if (!arst_n || branch_flush || pause || stall) begin
            e.fetch_inst_1_en = 1'b0;
            e.fetch_inst_2_en = 1'b0;
        end else if (take_1) begin
            e.fetch_inst_2_en = 1'b0;
            e.pre_taken       = 1'b1;
            e.pre_branch_addr = model_target[pc[`PC_INDEX_LSB +: `BTB_INDEX_BITS]];
        end else if (take_2) begin
            e.fetch_inst_1_en = 1'b1;
            e.fetch_inst_2_en = 1'b1;
            e.pre_taken       = 1'b1;
            e.pre_branch_addr = model_target[pc_2[`PC_INDEX_LSB +: `BTB_INDEX_BITS]];
        end
        return e;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // comparison
    ////////////////////////////////////////////////////////////////////////////

    task automatic verify_flag(string field, logic expected, logic actual);
        assert (expected === actual) else begin
            $display("Fail %s %s: expected %b, actual %b", test_name, field, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic compare_field(string field, logic [31:0] expected, logic [31:0] actual);
        assert (expected === actual) else begin
            $display("Fail %s %s: expected %h, actual %h", test_name, field, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // outputs are stable half a cycle after the drive
    always @(negedge clk) begin : compare_outputs
        expect_t e;
        if (checks_on) begin
            e = predict_outputs();
            verify_flag("is_branch_1", e.is_branch_1, is_branch_1);
            verify_flag("is_branch_2", e.is_branch_2, is_branch_2);
            verify_flag("pre_taken", e.pre_taken, pre_taken);
            compare_field("pre_branch_addr", e.pre_branch_addr, pre_branch_addr);
            verify_flag("fetch_inst_1_en", e.fetch_inst_1_en, fetch_inst_1_en);
            verify_flag("fetch_inst_2_en", e.fetch_inst_2_en, fetch_inst_2_en);
            verify_flag("is_exception", e.is_exception, is_exception);
            compare_field("exception_cause", {26'd0, e.exception_cause},
                {26'd0, exception_cause});
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic fetch(addr_t p, inst_t w1, inst_t w2, logic e1, logic e2);
        pc        = p;
        inst_1    = w1;
        inst_2    = w2;
        inst_en_1 = e1;
        inst_en_2 = e2;
    endtask

    task automatic train(addr_t bpc, logic taken, addr_t target);
        update_en     = 1'b1;
        update_pc     = bpc;
        update_taken  = taken;
        update_target = target;
        next_cycle();
        update_en     = 1'b0;
    endtask

    task automatic wait_for_taken(int limit);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!pre_taken && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!pre_taken) begin
            $display("timed out in %s waiting for a taken prediction", test_name);
            $display("ERRORS FOUND");
            $fatal(1, "no prediction within the wait limit");
        end
    endtask

    // expects the taken fetch already on the inputs
    task automatic hold_one(int kind);
        branch_flush = (kind == 0);
        pause        = (kind == 1);
        stall        = (kind == 2);
        @(negedge clk);
        verify_flag("gated slot 1 enable", 1'b0, fetch_inst_1_en);
        verify_flag("gated slot 2 enable", 1'b0, fetch_inst_2_en);
        verify_flag("gated pre_taken", 1'b0, pre_taken);
        next_cycle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [31:0] u;
        logic [31:0] t;
        opcode_t     op_a;
        opcode_t     op_b;

        seed            = 32'h4905_d81a;
        arst_n          = 1'b0;
        branch_flush    = 1'b0;
        pause           = 1'b0;
        stall           = 1'b0;
        fetch_exception = 1'b0;
        fetch_ecode     = '0;
        update_en       = 1'b0;
        update_pc       = '0;
        update_taken    = 1'b0;
        update_target   = '0;
        fetch('0, '0, '0, 1'b0, 1'b0);
        checks_on       = 1'b1;
        repeat (3) next_cycle();
        arst_n = 1'b1;

        // every opcode in both slots
        test_name = "opcode decode";
        for (int i = 0; i < 64; i++) begin
            r    = rand_word();
            op_a = i[5:0];
            op_b = 6'd63 - op_a;
            fetch({r[31:2], 2'b00}, {op_a, r[25:0]}, {op_b, r[27:2]}, 1'b1, 1'b1);
            next_cycle();
        end

        // empty tables never redirect
        test_name = "cold prediction";
        for (int i = 0; i < 8; i++) begin
            r = rand_word();
            fetch({r[31:2], 2'b00}, BR_WORD, BR_WORD, r[0] | r[1], r[0]);
            @(negedge clk);
            verify_flag("cold pre_taken", 1'b0, pre_taken);
            next_cycle();
        end

        test_name = "training";
        fetch('0, ALU_WORD, ALU_WORD, 1'b0, 1'b0);
        train(BR_A, 1'b1, TGT_A);
        train(BR_A, 1'b1, TGT_A);
        fetch(BR_A, BR_WORD, ALU_WORD, 1'b1, 1'b1);
        wait_for_taken(4);
        compare_field("slot 1 target", TGT_A, pre_branch_addr);
        verify_flag("slot 2 dropped", 1'b0, fetch_inst_2_en);
        next_cycle();

        test_name = "slot 2 taken";
        fetch(BR_A - 32'd4, ALU_WORD, BR_WORD, 1'b1, 1'b1);
        @(negedge clk);
        verify_flag("slot 2 pre_taken", 1'b1, pre_taken);
        verify_flag("slot 2 kept", 1'b1, fetch_inst_2_en);
        compare_field("slot 2 target", TGT_A, pre_branch_addr);
        next_cycle();

        test_name = "slot priority";
        fetch('0, ALU_WORD, ALU_WORD, 1'b0, 1'b0);
        train(BR_B, 1'b1, TGT_B);
        train(BR_B, 1'b1, TGT_B);
        fetch(BR_A, BR_WORD, BR_WORD, 1'b1, 1'b1);
        @(negedge clk);
        compare_field("first slot wins", TGT_A, pre_branch_addr);
        next_cycle();

        // saturated counter survives one not-taken, not two
        test_name = "hysteresis";
        fetch(BR_A, BR_WORD, ALU_WORD, 1'b1, 1'b1);
        train(BR_A, 1'b0, '0);
        @(negedge clk);
        verify_flag("after one not-taken", 1'b1, pre_taken);
        next_cycle();
        train(BR_A, 1'b0, '0);
        @(negedge clk);
        verify_flag("after two not-taken", 1'b0, pre_taken);
        next_cycle();

        test_name = "tag check";
        fetch(ALIAS, BR_WORD, ALU_WORD, 1'b1, 1'b1);
        @(negedge clk);
        verify_flag("aliased pc", 1'b0, pre_taken);
        next_cycle();

        test_name = "gating";
        fetch(BR_B, BR_WORD, ALU_WORD, 1'b1, 1'b1);
        for (int k = 0; k < 3; k++) begin
            hold_one(k);
        end
        branch_flush = 1'b0;
        pause        = 1'b0;
        stall        = 1'b0;
        arst_n       = 1'b0;
        @(negedge clk);
        verify_flag("reset slot 1 enable", 1'b0, fetch_inst_1_en);
        verify_flag("reset slot 2 enable", 1'b0, fetch_inst_2_en);
        verify_flag("reset pre_taken", 1'b0, pre_taken);
        repeat (2) next_cycle();
        arst_n = 1'b1;

        // random fetches and updates over a small pc pool so entries hit
        test_name = "exception delay";
        for (int n = 0; n < 300; n++) begin
            r = rand_word();
            u = rand_word();
            t = rand_word();
            op_a = r[12] ? (BR_OPCODE_FIRST + {2'b00, r[16:13]}) : r[18:13];
            op_b = u[12] ? (BR_OPCODE_FIRST + {2'b00, u[16:13]}) : u[18:13];
            fetch({20'd0, r[11:2], 2'b00}, {op_a, t[25:0]}, {op_b, t[31:6]},
                r[19] | r[20], (r[19] | r[20]) & r[21]);
            fetch_exception = r[22];
            fetch_ecode     = r[28:23];
            pause           = (r[31:29] == 3'd0);
            stall           = (u[31:29] == 3'd0);
            branch_flush    = (u[28:26] == 3'd0);
            update_en       = u[25];
            update_taken    = u[24] | u[23];
            update_pc       = {20'd0, u[11:2], 2'b00};
            update_target   = {t[31:2], 2'b00};
            next_cycle();
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== source/fetch_predict_top.sv ====
module fetch_predict_top
    import bpu_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,

    // fetch side
    input  addr_t  pc,
    input  inst_t  inst_1,
    input  inst_t  inst_2,
    input  logic   inst_en_1,
    input  logic   inst_en_2,
    input  logic   pause,
    input  logic   stall,
    input  logic   fetch_exception,
    input  ecode_t fetch_ecode,

    // back end training and flush
    input  logic   update_en,
    input  addr_t  update_pc,
    input  logic   update_taken,
    input  addr_t  update_target,
    input  logic   branch_flush,

    // prediction out
    output logic   is_branch_1,
    output logic   is_branch_2,
    output logic   pre_taken,
    output addr_t  pre_branch_addr,
    output logic   fetch_inst_1_en,
    output logic   fetch_inst_2_en,
    output logic   is_exception,
    output ecode_t exception_cause
);

    branch_update_if upd_if ();

    assign upd_if.update_en     = update_en;
    assign upd_if.update_pc     = update_pc;
    assign upd_if.update_taken  = update_taken;
    assign upd_if.update_target = update_target;
    assign upd_if.branch_flush  = branch_flush;

    bpu u_bpu (
        .clk             (clk),
        .arst_n          (arst_n),
        .upd             (upd_if.sink),
        .pc              (pc),
        .inst_1          (inst_1),
        .inst_2          (inst_2),
        .inst_en_1       (inst_en_1),
        .inst_en_2       (inst_en_2),
        .pause           (pause),
        .stall           (stall),
        .fetch_exception (fetch_exception),
        .fetch_ecode     (fetch_ecode),
        .is_branch_1     (is_branch_1),
        .is_branch_2     (is_branch_2),
        .pre_taken       (pre_taken),
        .pre_branch_addr (pre_branch_addr),
        .fetch_inst_1_en (fetch_inst_1_en),
        .fetch_inst_2_en (fetch_inst_2_en),
        .is_exception    (is_exception),
        .exception_cause (exception_cause)
    );

endmodule

// ==== source/bpu.sv ====
module bpu
    import bpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    branch_update_if.sink        upd,

    // fetch group
    input  addr_t                pc,
    input  inst_t                inst_1,
    input  inst_t                inst_2,
    input  logic                 inst_en_1,
    input  logic                 inst_en_2,
    input  logic                 pause,
    input  logic                 stall,
    input  logic                 fetch_exception,
    input  ecode_t               fetch_ecode,

    // prediction
    output logic                 is_branch_1,
    output logic                 is_branch_2,
    output logic                 pre_taken,
    output addr_t                pre_branch_addr,

    // to the instruction buffer
    output logic                 fetch_inst_1_en,
    output logic                 fetch_inst_2_en,
    output logic                 is_exception,
    output ecode_t               exception_cause
);

    addr_t    pc_2;
    counter_t counter_1;
    counter_t counter_2;
    logic     hit_1;
    logic     hit_2;
    addr_t    target_1;
    addr_t    target_2;
    logic     taken_1;
    logic     taken_2;
    logic     hold;

    // slot 2 is the next word
    assign pc_2 = pc + 32'd4;

    assign is_branch_1 = is_branch_op(inst_1[31:26]);
    assign is_branch_2 = is_branch_op(inst_2[31:26]);

    bht u_bht (
        .clk          (clk),
        .arst_n       (arst_n),
        .rd_pc_1      (pc),
        .rd_pc_2      (pc_2),
        .update_en    (upd.update_en),
        .update_pc    (upd.update_pc),
        .update_taken (upd.update_taken),
        .counter_1    (counter_1),
        .counter_2    (counter_2)
    );

    btb u_btb (
        .clk           (clk),
        .arst_n        (arst_n),
        .rd_pc_1       (pc),
        .rd_pc_2       (pc_2),
        .update_en     (upd.update_en),
        .update_pc     (upd.update_pc),
        .update_taken  (upd.update_taken),
        .update_target (upd.update_target),
        .hit_1         (hit_1),
        .hit_2         (hit_2),
        .target_1      (target_1),
        .target_2      (target_2)
    );

    ////////////////////////////////////////////////////////////////////////////
    // slot select
    ////////////////////////////////////////////////////////////////////////////

    // taken needs a valid branch, a taken counter and a btb hit
    assign taken_1 = inst_en_1 && is_branch_1 && (counter_1 >= CNT_WEAK_TAKEN) && hit_1;
    assign taken_2 = inst_en_2 && is_branch_2 && (counter_2 >= CNT_WEAK_TAKEN) && hit_2;

    // reset, flush, pause and stall all drop the fetch group
    assign hold = !arst_n || upd.branch_flush || pause || stall;

    always_comb begin
        fetch_inst_1_en = inst_en_1;
        fetch_inst_2_en = inst_en_2;
        pre_taken       = 1'b0;
        pre_branch_addr = '0;
        if (hold) begin
            fetch_inst_1_en = 1'b0;
            fetch_inst_2_en = 1'b0;
        end else if (taken_1) begin
            // slot 2 lies on the wrong path
            fetch_inst_1_en = 1'b1;
            fetch_inst_2_en = 1'b0;
            pre_taken       = 1'b1;
            pre_branch_addr = target_1;
        end else if (taken_2) begin
            fetch_inst_1_en = 1'b1;
            fetch_inst_2_en = 1'b1;
            pre_taken       = 1'b1;
            pre_branch_addr = target_2;
        end
    end

    // exception info lines up with the instruction buffer write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            is_exception    <= 1'b0;
            exception_cause <= '0;
        end else begin
            is_exception    <= fetch_exception;
            exception_cause <= fetch_ecode;
        end
    end

    // the buffer fills in order, slot 2 never alone
    a_slot_order : assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(fetch_inst_2_en) |-> fetch_inst_1_en
    );

endmodule

// ==== source/btb.sv ====
`include "bpu_cfg.svh"

module btb
    import bpu_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  addr_t rd_pc_1,
    input  addr_t rd_pc_2,
    input  logic  update_en,
    input  addr_t update_pc,
    input  logic  update_taken,
    input  addr_t update_target,
    output logic  hit_1,
    output logic  hit_2,
    output addr_t target_1,
    output addr_t target_2
);

    logic       valid   [`BTB_ENTRIES];
    btb_tag_t   tags    [`BTB_ENTRIES];
    addr_t      targets [`BTB_ENTRIES];

    btb_index_t rd_idx_1;
    btb_index_t rd_idx_2;
    btb_index_t upd_idx;
    logic       write_en;

    ////////////////////////////////////////////////////////////////////////////
    // lookup for both slots
    ////////////////////////////////////////////////////////////////////////////

    assign rd_idx_1 = btb_index(rd_pc_1);
    assign rd_idx_2 = btb_index(rd_pc_2);

    assign hit_1    = valid[rd_idx_1] && (tags[rd_idx_1] == btb_tag(rd_pc_1));
    assign hit_2    = valid[rd_idx_2] && (tags[rd_idx_2] == btb_tag(rd_pc_2));
    assign target_1 = targets[rd_idx_1];
    assign target_2 = targets[rd_idx_2];

    ////////////////////////////////////////////////////////////////////////////
    // allocation
    ////////////////////////////////////////////////////////////////////////////

    // only taken branches allocate, not-taken leaves the entry alone
    assign upd_idx  = btb_index(update_pc);
    assign write_en = update_en && update_taken;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (write_en) begin
            valid[upd_idx] <= 1'b1;
        end
    end

    // tag and target payload
    always_ff @(posedge clk) begin
        if (write_en) begin
            tags[upd_idx]    <= btb_tag(update_pc);
            targets[upd_idx] <= update_target;
        end
    end

    // a stored target later becomes a fetch pc
    a_target_aligned : assert property (
        @(posedge clk) disable iff (!arst_n)
        write_en |-> (update_target[1:0] == 2'b00)
    );

endmodule

// ==== source/bht.sv ====
`include "bpu_cfg.svh"

module bht
    import bpu_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  addr_t    rd_pc_1,
    input  addr_t    rd_pc_2,
    input  logic     update_en,
    input  addr_t    update_pc,
    input  logic     update_taken,
    output counter_t counter_1,
    output counter_t counter_2
);

    counter_t   counters [`BHT_ENTRIES];
    bht_index_t rd_idx_1;
    bht_index_t rd_idx_2;
    bht_index_t upd_idx;
    counter_t   cur_cnt;
    counter_t   next_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////////////////////

    assign rd_idx_1  = bht_index(rd_pc_1);
    assign rd_idx_2  = bht_index(rd_pc_2);
    assign counter_1 = counters[rd_idx_1];
    assign counter_2 = counters[rd_idx_2];

    ////////////////////////////////////////////////////////////////////////////
    // training
    ////////////////////////////////////////////////////////////////////////////

    assign upd_idx = bht_index(update_pc);
    assign cur_cnt = counters[upd_idx];

    // one saturating step per resolved branch
    always_comb begin
        next_cnt = cur_cnt;
        if (update_taken) begin
            if (cur_cnt != CNT_STRONG_TAKEN) begin
                next_cnt = cur_cnt + 2'd1;
            end
        end else begin
            if (cur_cnt != CNT_STRONG_NOT_TAKEN) begin
                next_cnt = cur_cnt - 2'd1;
            end
        end
    end

    // all entries start weakly not taken
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                counters[i] <= CNT_WEAK_NOT_TAKEN;
            end
        end else if (update_en) begin
            counters[upd_idx] <= next_cnt;
        end
    end

    // the back end must send a known pc with every strobe
    a_update_pc_known : assert property (
        @(posedge clk) disable iff (!arst_n)
        update_en |-> !$isunknown(update_pc)
    );

endmodule

// ==== source/branch_update_if.sv ====
// resolved branch training from the back end, plus the flush level
interface branch_update_if
    import bpu_pkg::*;
();

    logic  update_en;
    addr_t update_pc;
    logic  update_taken;
    addr_t update_target;
    logic  branch_flush;

    modport source (
        output update_en,
        output update_pc,
        output update_taken,
        output update_target,
        output branch_flush
    );

    modport sink (
        input update_en,
        input update_pc,
        input update_taken,
        input update_target,
        input branch_flush
    );

endinterface

// ==== source/bpu_pkg.sv ====
`include "bpu_cfg.svh"

package bpu_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [1:0]  counter_t;
    typedef logic [5:0]  ecode_t;

    typedef logic [`BHT_INDEX_BITS-1:0] bht_index_t;
    typedef logic [`BTB_INDEX_BITS-1:0] btb_index_t;
    typedef logic [`BTB_TAG_BITS-1:0]   btb_tag_t;

    // major opcodes of all branches, inclusive range
    localparam opcode_t BR_OPCODE_FIRST = 6'b010010;
    localparam opcode_t BR_OPCODE_LAST  = 6'b011011;

    // counter states
    localparam counter_t CNT_STRONG_NOT_TAKEN = 2'd0;
    localparam counter_t CNT_WEAK_NOT_TAKEN   = 2'd1;
    localparam counter_t CNT_WEAK_TAKEN       = 2'd2;
    localparam counter_t CNT_STRONG_TAKEN     = 2'd3;

    function automatic logic is_branch_op(opcode_t op);
        return (op >= BR_OPCODE_FIRST) && (op <= BR_OPCODE_LAST);
    endfunction

    function automatic bht_index_t bht_index(addr_t pc);
        return pc[`PC_INDEX_LSB +: `BHT_INDEX_BITS];
    endfunction

    function automatic btb_index_t btb_index(addr_t pc);
        return pc[`PC_INDEX_LSB +: `BTB_INDEX_BITS];
    endfunction

    function automatic btb_tag_t btb_tag(addr_t pc);
        return pc[`BTB_TAG_LSB +: `BTB_TAG_BITS];
    endfunction

endpackage

// ==== include/bpu_cfg.svh ====
`ifndef BPU_CFG_SVH
`define BPU_CFG_SVH

// table geometry of the branch predictor

// history table, 256 two-bit counters
`define BHT_INDEX_BITS 8
`define BHT_ENTRIES (1 << `BHT_INDEX_BITS)

// target buffer, 64 direct-mapped entries
`define BTB_INDEX_BITS 6
`define BTB_TAG_BITS 10
`define BTB_ENTRIES (1 << `BTB_INDEX_BITS)

// word address fields of a pc
`define PC_INDEX_LSB 2
`define BTB_TAG_LSB (`PC_INDEX_LSB + `BTB_INDEX_BITS)

`endif
